// File: hw/rot_pkg.sv
// Rotator package with chunk sizes, coefficient types and the pipeline request struct
package rot_pkg;

  // ==========================================================================
  // Sizes
  // ==========================================================================
  // Radix-2 permutation levels per chunk
  localparam int ROT_LVL_NB = 3;
  // log2 of the polynomial size
  localparam int N_SZ       = 6;
  // Rotation factor width, one extra bit for the negacyclic sign
  localparam int LWE_COEF_W = N_SZ + 1;
  localparam int CHUNK_NB   = 2 ** ROT_LVL_NB;
  localparam int COEF_W     = 16;

  // ==========================================================================
  // Types
  // ==========================================================================
  typedef logic [COEF_W-1:0] coef_t;
  typedef coef_t [CHUNK_NB-1:0] chunk_t;

  // One beat of the rotator pipeline
  typedef struct packed {
    logic                  vld;
    logic [LWE_COEF_W-1:0] rot_factor;
    chunk_t                data;
  } rot_req_t;

  // Reverse the lowest width bits of val
  // Used for select ordering in the swap levels
  function automatic int bit_rev(input int val, input int width);
    int res;
    res = 0;
    for (int b = 0; b < width; b++) begin
      if (val[b]) begin
        res[width-1-b] = 1'b1;
      end
    end
    return res;
  endfunction

endpackage

// File: hw/perm_vector.sv
// Swap-select vector for one radix-2 permutation level, derived from the rotation factor
module perm_vector #(
  parameter int PERM_LVL_NB = rot_pkg::ROT_LVL_NB,
  parameter int PERM_LVL    = 0,
  parameter int N_SZ        = rot_pkg::N_SZ
) (
  input  logic [rot_pkg::LWE_COEF_W-1:0] rot_factor,
  output logic [2**PERM_LVL-1:0]         perm_select
);

  // ==========================================================================
  // Shift field
  // ==========================================================================
  // Pairs handled by this level
  localparam int PERM_NB  = 2 ** PERM_LVL;
  // Factor bits that matter at this level
  localparam int MASK_BIT = PERM_LVL + 1;

  logic [PERM_LVL_NB-1:0] shift_field;
  logic [MASK_BIT-1:0]    factor;

  // Chunk shift sits just below the sign bit
  assign shift_field = rot_factor[N_SZ-1 -: PERM_LVL_NB];
  // Shift modulo the group size of this level
  assign factor      = shift_field[MASK_BIT-1:0];

  // ==========================================================================
  // Select vector
  // ==========================================================================
  if (PERM_LVL == 0) begin : gen_lvl_0
    // Single select, odd shift swaps every neighbour pair
    assign perm_select = factor[0];
  end else begin : gen_lvl_n
    logic [PERM_LVL-1:0] low_shift;
    logic                negate;
    logic [PERM_NB-1:0]  ones_vec;
    logic [PERM_NB-1:0]  rev_vec;

    // Shift within half a group
    assign low_shift = factor[PERM_LVL-1:0];
    // Top bit low means the shift stays inside the lower half
    assign negate    = (factor[PERM_LVL] == 1'b0);

    // Ones from the shift amount upward
    assign ones_vec = {PERM_NB{1'b1}} << low_shift;

    // Bit-reversed placement
    always_comb begin
      for (int i = 0; i < PERM_NB; i++) begin
        rev_vec[i] = ones_vec[rot_pkg::bit_rev(i, PERM_LVL)];
      end
    end

    // Invert for shifts below half a group
    assign perm_select = {PERM_NB{negate}} ^ rev_vec;
  end

endmodule

// File: hw/perm_level.sv
// Registered radix-2 swap stage of the chunk rotator with a generic payload type
module perm_level #(
  parameter int  PERM_LVL  = 0,
  parameter type payload_t = rot_pkg::coef_t
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              in_vld,
  input  logic [rot_pkg::LWE_COEF_W-1:0]    in_rot_factor,
  input  payload_t [rot_pkg::CHUNK_NB-1:0]  in_data,
  input  logic [2**PERM_LVL-1:0]            perm_select,
  output logic                              out_vld,
  output logic [rot_pkg::LWE_COEF_W-1:0]    out_rot_factor,
  output payload_t [rot_pkg::CHUNK_NB-1:0]  out_data
);

  // ==========================================================================
  // Swap network
  // ==========================================================================
  // Distance between pair members, also the number of pairs per group
  localparam int PAIR_DIST = 2 ** PERM_LVL;

  logic [PAIR_DIST-1:0]               pair_swap;
  payload_t [rot_pkg::CHUNK_NB-1:0]   swp_data;

  // Pair r of a group uses the select counted from the top, bit reversed
  always_comb begin
    for (int r = 0; r < PAIR_DIST; r++) begin
      pair_swap[r] = perm_select[PAIR_DIST-1-rot_pkg::bit_rev(r, PERM_LVL)];
    end
  end

  // Both members of a pair share the same swap decision
  always_comb begin
    for (int i = 0; i < rot_pkg::CHUNK_NB; i++) begin
      if (pair_swap[i % PAIR_DIST]) begin
        swp_data[i] = in_data[i ^ PAIR_DIST];
      end else begin
        swp_data[i] = in_data[i];
      end
    end
  end

  // ==========================================================================
  // Output register
  // ==========================================================================
  // Valid strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= in_vld;
    end
  end

  // Payload, factor travels with its chunk
  always_ff @(posedge clk) begin
    out_rot_factor <= in_rot_factor;
    out_data       <= swp_data;
  end

endmodule

// File: hw/rot_network.sv
// Chain of registered swap levels that rotates a coefficient chunk by the rotation factor
module rot_network (
  input  logic              clk,
  input  logic              rst_n,
  input  rot_pkg::rot_req_t in_req,
  output rot_pkg::rot_req_t out_req
);

  // ==========================================================================
  // Stage chain
  // ==========================================================================
  // Entry 0 is the network input, entry s+1 the output of stage s
  rot_pkg::rot_req_t stage_req [0:rot_pkg::ROT_LVL_NB];

  assign stage_req[0] = in_req;

  // Stage s runs permutation level ROT_LVL_NB-1-s
  // Highest level first, level 0 last
  for (genvar s = 0; s < rot_pkg::ROT_LVL_NB; s++) begin : gen_stage
    logic [2**(rot_pkg::ROT_LVL_NB-1-s)-1:0] perm_select;
    logic                                    lvl_vld;
    logic [rot_pkg::LWE_COEF_W-1:0]          lvl_rot_factor;
    rot_pkg::chunk_t                         lvl_data;

    // Select from the factor entering this stage
    // Keeps beats with different factors independent
    perm_vector #(
      .PERM_LVL_NB (rot_pkg::ROT_LVL_NB),
      .PERM_LVL    (rot_pkg::ROT_LVL_NB - 1 - s),
      .N_SZ        (rot_pkg::N_SZ)
    ) i_perm_vector (
      .rot_factor  (stage_req[s].rot_factor),
      .perm_select (perm_select)
    );

    // One cycle per level
    perm_level #(
      .PERM_LVL  (rot_pkg::ROT_LVL_NB - 1 - s),
      .payload_t (rot_pkg::coef_t)
    ) i_perm_level (
      .clk            (clk),
      .rst_n          (rst_n),
      .in_vld         (stage_req[s].vld),
      .in_rot_factor  (stage_req[s].rot_factor),
      .in_data        (stage_req[s].data),
      .perm_select    (perm_select),
      .out_vld        (lvl_vld),
      .out_rot_factor (lvl_rot_factor),
      .out_data       (lvl_data)
    );

    // Repack for the next stage
    assign stage_req[s+1] = '{
      vld:        lvl_vld,
      rot_factor: lvl_rot_factor,
      data:       lvl_data
    };
  end

  // ==========================================================================
  // Output
  // ==========================================================================
  // Rotated chunk after the level 0 stage
  assign out_req = stage_req[rot_pkg::ROT_LVL_NB];

endmodule

// File: hw/rot_top.sv
// Coefficient rotator top level with input register stage in front of the swap network
module rot_top (
  input  logic              clk,
  input  logic              rst_n,
  input  rot_pkg::rot_req_t in_req,
  output rot_pkg::rot_req_t out_req
);

  // ==========================================================================
  // Input register
  // ==========================================================================
  rot_pkg::rot_req_t in_req_q;

  // Valid strobe, low after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_req_q.vld <= 1'b0;
    end else begin
      in_req_q.vld <= in_req.vld;
    end
  end

  // Factor and chunk
  always_ff @(posedge clk) begin
    in_req_q.rot_factor <= in_req.rot_factor;
    in_req_q.data       <= in_req.data;
  end

  // ==========================================================================
  // Rotation network
  // ==========================================================================
  // One cycle per level on top of the input stage
  rot_network i_rot_network (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req_q),
    .out_req (out_req)
  );

endmodule

// File: verification/rot_assert.sv
// Concurrent checks on the rotator valid pipeline, bound to the top level
module rot_assert (
  input logic              clk,
  input logic              rst_n,
  input rot_pkg::rot_req_t in_req,
  input rot_pkg::rot_req_t out_req
);

  // ==========================================================================
  // Pipeline properties
  // ==========================================================================
  // Input register plus one cycle per level
  localparam int LATENCY = rot_pkg::ROT_LVL_NB + 1;

  // Valid follows the input after the full pipeline depth
  property p_vld_latency;
    @(posedge clk) disable iff (!rst_n)
      out_req.vld == $past(in_req.vld, LATENCY);
  endproperty

  // Factor travels with its beat
  property p_factor_latency;
    @(posedge clk) disable iff (!rst_n)
      out_req.vld |-> (out_req.rot_factor == $past(in_req.rot_factor, LATENCY));
  endproperty

  // Sync reset clears the output valid on the next edge
  property p_reset_clears_vld;
    @(posedge clk) !rst_n |=> !out_req.vld;
  endproperty

  a_vld_latency:      assert property (p_vld_latency)
    else $error("out_req.vld does not follow in_req.vld");
  a_factor_latency:   assert property (p_factor_latency)
    else $error("out_req.rot_factor does not follow in_req.rot_factor");
  a_reset_clears_vld: assert property (p_reset_clears_vld)
    else $error("out_req.vld high while in reset");

endmodule

// File: verification/tb_rot_top.sv
// Testbench for the coefficient rotator, pattern-driven with a queue-based reference model
module tb_rot_top;

  // ==========================================================================
  // Constants
  // ==========================================================================
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 2;
  // Lines in the pattern file
  localparam int NUM_LINES    = 28;
  // valid nibble, factor byte, shift nibble, eight coefficients
  localparam int PAT_W        = 144;
  // Input register plus one cycle per level
  localparam int LATENCY      = rot_pkg::ROT_LVL_NB + 1;
  localparam int TIMEOUT_CYC  = NUM_LINES + 20;

  typedef logic [rot_pkg::ROT_LVL_NB-1:0] idx_t;

  logic              clk;
  logic              rst_n;
  rot_pkg::rot_req_t in_req;
  rot_pkg::rot_req_t out_req;

  logic [PAT_W-1:0]  patterns [0:NUM_LINES-1];
  // Expected beats in issue order
  rot_pkg::rot_req_t exp_q [$];

  int sent_beats;
  int recv_beats;
  int data_errors;
  int factor_errors;
  int beat_errors;

  // ==========================================================================
  // DUT and assertions
  // ==========================================================================
  rot_top i_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .out_req (out_req)
  );

  bind rot_top rot_assert i_rot_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_req  (in_req),
    .out_req (out_req)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ==========================================================================
  // Reference model
  // ==========================================================================
  // Output i takes input (i - f) mod CHUNK_NB
  // Index wraps in idx_t
  function automatic rot_pkg::chunk_t rotate_chunk(input rot_pkg::chunk_t chunk,
                                                   input int shift);
    rot_pkg::chunk_t res;
    for (int i = 0; i < rot_pkg::CHUNK_NB; i++) begin
      res[idx_t'(i)] = chunk[idx_t'(i - shift)];
    end
    return res;
  endfunction

  // Drive one pattern line and queue its expected beat if valid
  task automatic drive_line(input logic [PAT_W-1:0] pat);
    rot_pkg::rot_req_t req;
    rot_pkg::rot_req_t exp_req;
    // Low bit of each nibble or byte column
    req.vld        = pat[140];
    req.rot_factor = pat[138:132];
    req.data       = pat[127:0];
    in_req <= req;
    if (req.vld) begin
      exp_req.vld        = 1'b1;
      exp_req.rot_factor = req.rot_factor;
      // Expected shift from its own column
      exp_req.data       = rotate_chunk(req.data, int'(pat[130:128]));
      exp_q.push_back(exp_req);
      sent_beats++;
    end
  endtask

  // ==========================================================================
  // Stimulus and end of run
  // ==========================================================================
  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    in_req        = '0;
    sent_beats    = 0;
    recv_beats    = 0;
    data_errors   = 0;
    factor_errors = 0;
    beat_errors   = 0;
    $readmemh("verification/rot_patterns.txt", patterns);

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // One line per cycle, idle lines leave gaps
    for (int n = 0; n < NUM_LINES; n++) begin
      drive_line(patterns[n]);
      @(posedge clk);
    end
    in_req.vld <= 1'b0;

    // Drain and then idle cycles to catch extra beats
    wait (recv_beats >= sent_beats);
    repeat (LATENCY + 2) @(posedge clk);

    assert (recv_beats == sent_beats) else begin
      $display("Error: time %0t, %0d beats in, %0d beats out", $time,
               sent_beats, recv_beats);
      beat_errors++;
    end

    $display("Summary: %0d data errors, %0d factor errors, %0d beat count errors",
             data_errors, factor_errors, beat_errors);
    if (data_errors + factor_errors + beat_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // ==========================================================================
  // Output monitor
  // ==========================================================================
  // Sampled on the falling edge away from register updates
  always @(negedge clk) begin
    rot_pkg::rot_req_t exp_req;
    if (rst_n && out_req.vld) begin
      recv_beats++;
      assert (exp_q.size() > 0) else begin
        $display("An output beat at time %0t has no input beat left to match", $time);
        beat_errors++;
      end
      if (exp_q.size() > 0) begin
        exp_req = exp_q.pop_front();
        assert (out_req.data == exp_req.data) else begin
          $display("Error: time %0t, factor %h, data %h, expected %h", $time,
                   exp_req.rot_factor, out_req.data, exp_req.data);
          data_errors++;
        end
        // Factor carried with its chunk
        assert (out_req.rot_factor == exp_req.rot_factor) else begin
          $display("Error: time %0t, rot_factor %h, expected %h", $time,
                   out_req.rot_factor, exp_req.rot_factor);
          factor_errors++;
        end
      end
    end
  end

  // ==========================================================================
  // Watchdog
  // ==========================================================================
  initial begin
    #((RESET_CYCLES + TIMEOUT_CYC) * CLK_PERIOD);
    $display("Timeout: output beats still missing after %0d cycles",
             RESET_CYCLES + TIMEOUT_CYC);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: verification/rot_patterns.txt
// Columns: valid _ rot_factor _ expected shift _ coefficients 7 down to 0, all hex
// Shift field is rot_factor[5:3]; bit 6 and bits 2:0 leave the rotation unchanged
0_00_0_0000_0000_0000_0000_0000_0000_0000_0000
1_00_0_0177_0166_0155_0144_0133_0122_0111_0100
0_00_0_0000_0000_0000_0000_0000_0000_0000_0000
1_08_1_0277_0266_0255_0244_0233_0222_0211_0200
1_10_2_0377_0366_0355_0344_0333_0322_0311_0300
1_18_3_0477_0466_0455_0444_0433_0422_0411_0400
1_20_4_0577_0566_0555_0544_0533_0522_0511_0500
1_28_5_0677_0666_0655_0644_0633_0622_0611_0600
1_30_6_0777_0766_0755_0744_0733_0722_0711_0700
1_38_7_0877_0866_0855_0844_0833_0822_0811_0800
0_38_0_DEAD_BEEF_DEAD_BEEF_DEAD_BEEF_DEAD_BEEF
0_00_0_0000_0000_0000_0000_0000_0000_0000_0000
1_47_0_0977_0966_0955_0944_0933_0922_0911_0900
1_4D_1_0A77_0A66_0A55_0A44_0A33_0A22_0A11_0A00
1_7F_7_0B77_0B66_0B55_0B44_0B33_0B22_0B11_0B00
1_15_2_0C77_0C66_0C55_0C44_0C33_0C22_0C11_0C00
1_63_4_0D77_0D66_0D55_0D44_0D33_0D22_0D11_0D00
0_7F_0_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF
1_2E_5_0E77_0E66_0E55_0E44_0E33_0E22_0E11_0E00
1_0B_1_0F77_0F66_0F55_0F44_0F33_0F22_0F11_0F00
1_3A_7_1077_1066_1055_1044_1033_1022_1011_1000
1_19_3_1177_1166_1155_1144_1133_1122_1111_1100
1_56_2_1277_1266_1255_1244_1233_1222_1211_1200
1_71_6_FFFF_8001_7FFE_0000_AAAA_5555_C3C3_3C3C
1_04_0_1477_1466_1455_1444_1433_1422_1411_1400
0_00_0_0000_0000_0000_0000_0000_0000_0000_0000
1_21_4_1577_1566_1555_1544_1533_1522_1511_1500
0_00_0_0000_0000_0000_0000_0000_0000_0000_0000

// File: sources.f
hw/rot_pkg.sv
hw/perm_vector.sv
hw/perm_level.sv
hw/rot_network.sv
hw/rot_top.sv
verification/rot_assert.sv
verification/tb_rot_top.sv

// File: Makefile
# Verilator build and run for the coefficient rotator testbench

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/Vtb_rot_top
SOURCES := $(shell cat sources.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(SOURCES)
	verilator --binary --assert -j 0 --top-module tb_rot_top \
		-f sources.f --Mdir $(OBJ_DIR) -o Vtb_rot_top

# Pass only if the log holds the pass message
run: $(SIM) verification/rot_patterns.txt
	./$(SIM) 2>&1 | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
